/* include/uart_config.svh */
// UART configuration constants
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Frame format
`define UART_DATA_BITS 8

// Baud divisor in clock cycles per bit
`define UART_DIV_WIDTH 16
`define UART_DIV_RESET 16

// Register byte offsets on the bus
`define UART_REG_DATA   0
`define UART_REG_STATUS 4
`define UART_REG_BAUD   8

`endif

/* src/uart_types_pkg.sv */
// UART datapath types
`include "uart_config.svh"

package uart_types_pkg;

    typedef logic [`UART_DATA_BITS-1:0] uart_data_t;
    typedef logic [`UART_DIV_WIDTH-1:0] baud_div_t;

    // Enough to count the data bits still to go
    typedef logic [3:0] bit_count_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

/* src/wb_types_pkg.sv */
// Wishbone bus types
package wb_types_pkg;

    // Byte address inside the peripheral window
    typedef logic [3:0]  wb_addr_t;

    typedef logic [31:0] wb_data_t;

    // Decoded register
    typedef enum logic [1:0] {
        SEL_DATA,
        SEL_STATUS,
        SEL_BAUD,
        SEL_NONE
    } reg_sel_e;

endpackage

/* src/uart_line_if.sv */
// Register block to serial engine link
interface uart_line_if;

    // Shared bit timing
    uart_types_pkg::baud_div_t  baud_div;

    // Transmit side
    uart_types_pkg::uart_data_t tx_data;
    logic                       tx_start;
    logic                       tx_busy;

    // Receive side, single-cycle result pulses
    uart_types_pkg::uart_data_t rx_data;
    logic                       rx_valid;
    logic                       rx_frame_err;

    modport regs (
        output baud_div, tx_data, tx_start,
        input  tx_busy, rx_data, rx_valid, rx_frame_err
    );

    modport tx (
        input  baud_div, tx_data, tx_start,
        output tx_busy
    );

    modport rx (
        input  baud_div,
        output rx_data, rx_valid, rx_frame_err
    );

endinterface

/* src/uart_rx.sv */
// UART serial receiver
`include "uart_config.svh"

module uart_rx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx_serial_i,
    uart_line_if.rx     line
);

    // Two-flop synchronizer plus one stage for edge detection
    logic [1:0] rx_sync;
    logic       rx_line;
    logic       rx_line_d;
    logic       start_edge;

    uart_types_pkg::rx_state_e  state;
    uart_types_pkg::baud_div_t  sample_cnt;
    uart_types_pkg::bit_count_t bit_cnt;
    uart_types_pkg::uart_data_t shifter;

    logic sample_pulse;
    logic valid_q;
    logic frame_err_q;

    assign rx_line      = rx_sync[1];
    assign start_edge   = rx_line_d && !rx_line;
    assign sample_pulse = (sample_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync   <= 2'b11;
            rx_line_d <= 1'b1;
        end else begin
            rx_sync   <= {rx_sync[0], rx_serial_i};
            rx_line_d <= rx_line;
        end
    end

    // Frame state machine with sample and bit counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= uart_types_pkg::RX_IDLE;
            sample_cnt  <= '0;
            bit_cnt     <= '0;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            case (state)
                uart_types_pkg::RX_IDLE: begin
                    // Half a divisor gets us to the middle of the start bit
                    if (start_edge) begin
                        state      <= uart_types_pkg::RX_START;
                        sample_cnt <= (line.baud_div >> 1) - 1'b1;
                    end
                end
                uart_types_pkg::RX_START: begin
                    if (rx_line) begin
                        // Glitch, not a real start bit
                        state <= uart_types_pkg::RX_IDLE;
                    end else if (sample_pulse) begin
                        state      <= uart_types_pkg::RX_DATA;
                        sample_cnt <= line.baud_div - 1'b1;
                        bit_cnt    <= uart_types_pkg::bit_count_t'(`UART_DATA_BITS);
                    end else begin
                        sample_cnt <= sample_cnt - 1'b1;
                    end
                end
                uart_types_pkg::RX_DATA: begin
                    if (sample_pulse) begin
                        sample_cnt <= line.baud_div - 1'b1;
                        bit_cnt    <= bit_cnt - 1'b1;
                        if (bit_cnt == uart_types_pkg::bit_count_t'(1)) begin
                            state <= uart_types_pkg::RX_STOP;
                        end
                    end else begin
                        sample_cnt <= sample_cnt - 1'b1;
                    end
                end
                uart_types_pkg::RX_STOP: begin
                    if (sample_pulse) begin
                        state       <= uart_types_pkg::RX_IDLE;
                        valid_q     <= rx_line;
                        frame_err_q <= !rx_line;
                    end else begin
                        sample_cnt <= sample_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= uart_types_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Serial to parallel, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == uart_types_pkg::RX_DATA && sample_pulse) begin
            shifter <= {rx_line, shifter[`UART_DATA_BITS-1:1]};
        end
    end

    assign line.rx_data      = shifter;
    assign line.rx_valid     = valid_q;
    assign line.rx_frame_err = frame_err_q;

endmodule

/* src/uart_tx.sv */
// UART serial transmitter
`include "uart_config.svh"

module uart_tx (
    input  logic        clk,
    input  logic        rst_n,
    output logic        tx_serial_o,
    uart_line_if.tx     line
);

    uart_types_pkg::tx_state_e  state;
    uart_types_pkg::baud_div_t  bit_timer;
    uart_types_pkg::bit_count_t bit_cnt;
    uart_types_pkg::uart_data_t shifter;

    logic tx_q;
    logic bit_done;

    assign bit_done = (bit_timer == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= uart_types_pkg::TX_IDLE;
            bit_timer <= '0;
            bit_cnt   <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state)
                uart_types_pkg::TX_IDLE: begin
                    if (line.tx_start) begin
                        state     <= uart_types_pkg::TX_START;
                        bit_timer <= line.baud_div - 1'b1;
                        tx_q      <= 1'b0;
                    end
                end
                uart_types_pkg::TX_START: begin
                    if (bit_done) begin
                        state     <= uart_types_pkg::TX_DATA;
                        bit_timer <= line.baud_div - 1'b1;
                        bit_cnt   <= uart_types_pkg::bit_count_t'(`UART_DATA_BITS);
                        tx_q      <= shifter[0];
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                uart_types_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_timer <= line.baud_div - 1'b1;
                        bit_cnt   <= bit_cnt - 1'b1;
                        // Last data bit done, go to the stop bit
                        if (bit_cnt == uart_types_pkg::bit_count_t'(1)) begin
                            state <= uart_types_pkg::TX_STOP;
                            tx_q  <= 1'b1;
                        end else begin
                            tx_q <= shifter[0];
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                uart_types_pkg::TX_STOP: begin
                    if (bit_done) begin
                        state <= uart_types_pkg::TX_IDLE;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                default: begin
                    state <= uart_types_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Byte latch and shift, next bit always sits at position 0
    always_ff @(posedge clk) begin
        if (state == uart_types_pkg::TX_IDLE && line.tx_start) begin
            shifter <= line.tx_data;
        end else if (bit_done && state != uart_types_pkg::TX_IDLE
                     && state != uart_types_pkg::TX_STOP) begin
            shifter <= shifter >> 1;
        end
    end

    assign tx_serial_o  = tx_q;
    assign line.tx_busy = (state != uart_types_pkg::TX_IDLE);

endmodule

/* src/uart_wb_regs.sv */
// Wishbone register block
`include "uart_config.svh"

module uart_wb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  wb_types_pkg::wb_addr_t  wb_adr_i,
    input  wb_types_pkg::wb_data_t  wb_dat_i,
    output wb_types_pkg::wb_data_t  wb_dat_o,
    output logic                    wb_ack_o,
    uart_line_if.regs               line
);

    wb_types_pkg::reg_sel_e     reg_sel;
    wb_types_pkg::wb_data_t     rd_mux;
    wb_types_pkg::wb_data_t     status;

    logic ack_q;
    logic access;
    logic wr_data;
    logic rd_data;
    logic wr_status;
    logic wr_baud;

    uart_types_pkg::baud_div_t  baud_div;
    uart_types_pkg::uart_data_t rx_buf;
    uart_types_pkg::uart_data_t tx_buf;
    logic                       tx_start_q;
    logic                       rx_full;
    logic                       frame_err;
    logic                       overrun;

    always_comb begin
        case (wb_adr_i)
            wb_types_pkg::wb_addr_t'(`UART_REG_DATA):   reg_sel = wb_types_pkg::SEL_DATA;
            wb_types_pkg::wb_addr_t'(`UART_REG_STATUS): reg_sel = wb_types_pkg::SEL_STATUS;
            wb_types_pkg::wb_addr_t'(`UART_REG_BAUD):   reg_sel = wb_types_pkg::SEL_BAUD;
            default:                                    reg_sel = wb_types_pkg::SEL_NONE;
        endcase
    end

    // One wait state and the access acts on the edge that raises ack
    assign access    = wb_cyc_i && wb_stb_i && !ack_q;
    assign wr_data   = access && wb_we_i && (reg_sel == wb_types_pkg::SEL_DATA);
    assign rd_data   = access && !wb_we_i && (reg_sel == wb_types_pkg::SEL_DATA);
    assign wr_status = access && wb_we_i && (reg_sel == wb_types_pkg::SEL_STATUS);
    assign wr_baud   = access && wb_we_i && (reg_sel == wb_types_pkg::SEL_BAUD);

    // Bit 0 tx_busy, bit 1 rx_full, bit 2 frame_err, bit 3 overrun
    assign status = wb_types_pkg::wb_data_t'({overrun, frame_err, rx_full, line.tx_busy});

    always_comb begin
        case (reg_sel)
            wb_types_pkg::SEL_DATA:   rd_mux = wb_types_pkg::wb_data_t'(rx_buf);
            wb_types_pkg::SEL_STATUS: rd_mux = status;
            wb_types_pkg::SEL_BAUD:   rd_mux = wb_types_pkg::wb_data_t'(baud_div);
            default:                  rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            tx_start_q <= 1'b0;
            baud_div   <= uart_types_pkg::baud_div_t'(`UART_DIV_RESET);
            rx_full    <= 1'b0;
            frame_err  <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            ack_q      <= access;
            // Writes while the transmitter is busy are dropped
            tx_start_q <= wr_data && !line.tx_busy;

            if (wr_baud) begin
                baud_div <= wb_dat_i[`UART_DIV_WIDTH-1:0];
            end

            // A read on the same edge as a new byte frees the buffer for it
            if (line.rx_valid && rx_full && !rd_data) begin
                overrun <= 1'b1;
            end else if (wr_status && wb_dat_i[3]) begin
                overrun <= 1'b0;
            end

            if (line.rx_valid) begin
                rx_full <= 1'b1;
            end else if (rd_data) begin
                rx_full <= 1'b0;
            end

            if (line.rx_frame_err) begin
                frame_err <= 1'b1;
            end else if (wr_status && wb_dat_i[2]) begin
                frame_err <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_o <= rd_mux;
        end
        if (wr_data && !line.tx_busy) begin
            tx_buf <= wb_dat_i[`UART_DATA_BITS-1:0];
        end
        if (line.rx_valid && (!rx_full || rd_data)) begin
            rx_buf <= line.rx_data;
        end
    end

    assign wb_ack_o      = ack_q;
    assign line.baud_div = baud_div;
    assign line.tx_data  = tx_buf;
    assign line.tx_start = tx_start_q;

endmodule

/* src/uart_top.sv */
// UART peripheral top level
module uart_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Wishbone classic slave
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  wb_types_pkg::wb_addr_t  wb_adr_i,
    input  wb_types_pkg::wb_data_t  wb_dat_i,
    output wb_types_pkg::wb_data_t  wb_dat_o,
    output logic                    wb_ack_o,

    // Serial pins
    input  logic                    uart_rx_i,
    output logic                    uart_tx_o
);

    uart_line_if line_bus ();

    uart_wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .line     (line_bus.regs)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_serial_i (uart_rx_i),
        .line        (line_bus.rx)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_serial_o (uart_tx_o),
        .line        (line_bus.tx)
    );

endmodule

/* tests/uart_tb.sv */
// UART peripheral testbench
`include "uart_config.svh"

module uart_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {
        KIND_TX,
        KIND_RX,
        KIND_RX_BAD_STOP,
        KIND_BAUD
    } test_kind_e;

    localparam int N_ENTRIES   = 10;
    localparam int MAX_DIV     = 16;
    localparam int WATCHDOG_NS = N_ENTRIES * 12 * MAX_DIV * 4 * 2;
    localparam int ACK_LIMIT   = 8;
    localparam int POLL_LIMIT  = 64;

    // Status register bits
    localparam wb_types_pkg::wb_data_t ST_TX_BUSY   = 32'h1;
    localparam wb_types_pkg::wb_data_t ST_RX_FULL   = 32'h2;
    localparam wb_types_pkg::wb_data_t ST_FRAME_ERR = 32'h4;
    localparam wb_types_pkg::wb_data_t ST_OVERRUN   = 32'h8;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    wb_types_pkg::wb_addr_t wb_adr;
    wb_types_pkg::wb_data_t wb_dat_w;
    wb_types_pkg::wb_data_t wb_dat_r;
    logic                   wb_ack;
    logic                   uart_rx;
    logic                   uart_tx;

    // Stimulus table and reference state
    string                      entry_name   [N_ENTRIES];
    test_kind_e                 entry_kind   [N_ENTRIES];
    uart_types_pkg::uart_data_t entry_byte   [N_ENTRIES];
    wb_types_pkg::wb_data_t     entry_status [N_ENTRIES];
    logic                       entry_drain  [N_ENTRIES];
    logic [31:0]                lcg_state;
    uart_types_pkg::baud_div_t  cur_div;
    uart_types_pkg::uart_data_t model_buf;
    logic                       model_full;

    uart_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .uart_rx_i(uart_rx),
        .uart_tx_o(uart_tx)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input uart_types_pkg::uart_data_t exp,
                              input uart_types_pkg::uart_data_t act);
        if (act !== exp) abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input wb_types_pkg::wb_data_t exp,
                                input wb_types_pkg::wb_data_t act);
        if (act !== exp) abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_div(input string name, input uart_types_pkg::baud_div_t exp,
                             input uart_types_pkg::baud_div_t act);
        if (act !== exp) abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    function automatic uart_types_pkg::uart_data_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    // One classic cycle that returns once ack has been seen
    task automatic bus_cycle(input logic we, input int addr, input wb_types_pkg::wb_data_t wdata,
                             output wb_types_pkg::wb_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = wb_types_pkg::wb_addr_t'(addr);
        wb_dat_w = wdata;
        @(posedge clk);
        #1;
        while (wb_ack !== 1'b1) begin
            if (waited == ACK_LIMIT) abort_run("bus access was never acknowledged");
            waited++;
            @(posedge clk);
            #1;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input int addr, input wb_types_pkg::wb_data_t data);
        wb_types_pkg::wb_data_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input int addr, output wb_types_pkg::wb_data_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    // Poll status until the masked bits match
    task automatic wait_status(input string name, input wb_types_pkg::wb_data_t mask,
                               input wb_types_pkg::wb_data_t value,
                               output wb_types_pkg::wb_data_t st);
        int tries;
        tries = 0;
        bus_read(`UART_REG_STATUS, st);
        while ((st & mask) !== value) begin
            if (tries == POLL_LIMIT) begin
                abort_run($sformatf("%s: status never reached %h", name, value));
            end
            tries++;
            bus_read(`UART_REG_STATUS, st);
        end
    endtask

    task automatic drive_bit(input logic level);
        uart_rx = level;
        repeat (int'(cur_div)) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input uart_types_pkg::uart_data_t data, input logic stop_level);
        @(posedge clk);
        #1;
        drive_bit(1'b0);
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_level);
        // One idle bit before anyone looks at the result
        drive_bit(1'b1);
    endtask

    task automatic capture_frame(input string name, output uart_types_pkg::uart_data_t data);
        int waited;
        waited = 0;
        data   = '0;
        @(posedge clk);
        #1;
        while (uart_tx !== 1'b0) begin
            if (waited == 4 * MAX_DIV) begin
                abort_run($sformatf("%s: transmit line never went low", name));
            end
            waited++;
            @(posedge clk);
            #1;
        end
        // Middle of the start bit and one bit time per sample after it
        repeat (int'(cur_div) / 2) @(posedge clk);
        #1;
        if (uart_tx !== 1'b0) abort_run($sformatf("%s: start bit did not stay low", name));
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            repeat (int'(cur_div)) @(posedge clk);
            #1;
            data[i] = uart_tx;
        end
        repeat (int'(cur_div)) @(posedge clk);
        #1;
        if (uart_tx !== 1'b1) abort_run($sformatf("%s: stop bit was not high", name));
    endtask

    task automatic add_entry(input int idx, input string name, input test_kind_e kind,
                             input uart_types_pkg::uart_data_t data,
                             input wb_types_pkg::wb_data_t status, input logic drain);
        entry_name[idx]   = name;
        entry_kind[idx]   = kind;
        entry_byte[idx]   = data;
        entry_status[idx] = status;
        entry_drain[idx]  = drain;
    endtask

    task automatic run_entry(input int idx);
        string                      name;
        uart_types_pkg::uart_data_t data;
        uart_types_pkg::uart_data_t got;
        wb_types_pkg::wb_data_t     exp;
        wb_types_pkg::wb_data_t     rd;
        wb_types_pkg::wb_data_t     done_mask;
        name = entry_name[idx];
        data = entry_byte[idx];
        exp  = entry_status[idx];
        case (entry_kind[idx])
            KIND_BAUD: begin
                bus_write(`UART_REG_BAUD, wb_types_pkg::wb_data_t'(data));
                bus_read(`UART_REG_BAUD, rd);
                check_div(name, uart_types_pkg::baud_div_t'(data), rd[`UART_DIV_WIDTH-1:0]);
                cur_div = uart_types_pkg::baud_div_t'(data);
                bus_read(`UART_REG_STATUS, rd);
                check_status(name, exp, rd);
            end
            KIND_TX: begin
                fork
                    begin
                        bus_write(`UART_REG_DATA, wb_types_pkg::wb_data_t'(data));
                        bus_read(`UART_REG_STATUS, rd);
                        check_status(name, exp | ST_TX_BUSY, rd);
                    end
                    capture_frame(name, got);
                join
                check_byte(name, data, got);
                wait_status(name, ST_TX_BUSY, '0, rd);
                check_status(name, exp, rd);
            end
            KIND_RX: begin
                // Buffer keeps the oldest unread byte
                if (!model_full) begin
                    model_buf  = data;
                    model_full = 1'b1;
                end
                send_frame(data, 1'b1);
                done_mask = ((exp & ST_OVERRUN) != '0) ? ST_OVERRUN : ST_RX_FULL;
                wait_status(name, done_mask, done_mask, rd);
                check_status(name, exp, rd);
                if (entry_drain[idx]) begin
                    bus_read(`UART_REG_DATA, rd);
                    check_byte(name, model_buf, rd[`UART_DATA_BITS-1:0]);
                    model_full = 1'b0;
                    bus_read(`UART_REG_STATUS, rd);
                    check_status(name, exp & ~ST_RX_FULL, rd);
                    if ((exp & ~ST_RX_FULL) != '0) begin
                        bus_write(`UART_REG_STATUS, exp & ~ST_RX_FULL);
                        bus_read(`UART_REG_STATUS, rd);
                        check_status(name, '0, rd);
                    end
                end
            end
            KIND_RX_BAD_STOP: begin
                send_frame(data, 1'b0);
                wait_status(name, ST_FRAME_ERR, ST_FRAME_ERR, rd);
                check_status(name, exp, rd);
                bus_write(`UART_REG_STATUS, ST_FRAME_ERR);
                bus_read(`UART_REG_STATUS, rd);
                check_status(name, '0, rd);
            end
        endcase
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the tests did not finish within the watchdog time");
    end

    initial begin
        wb_types_pkg::wb_data_t rd;
        clk        = 1'b0;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        uart_rx    = 1'b1;
        lcg_state  = 32'hbdbf911b;
        cur_div    = uart_types_pkg::baud_div_t'(`UART_DIV_RESET);
        model_buf  = '0;
        model_full = 1'b0;

        add_entry(0, "baud_16", KIND_BAUD, 8'd16, '0, 1'b0);
        add_entry(1, "tx_first", KIND_TX, rand_byte(), '0, 1'b0);
        add_entry(2, "rx_first", KIND_RX, rand_byte(), ST_RX_FULL, 1'b1);
        add_entry(3, "rx_bad_stop", KIND_RX_BAD_STOP, rand_byte(), ST_FRAME_ERR, 1'b0);
        add_entry(4, "rx_held", KIND_RX, rand_byte(), ST_RX_FULL, 1'b0);
        add_entry(5, "rx_overrun", KIND_RX, rand_byte(), ST_RX_FULL | ST_OVERRUN, 1'b1);
        add_entry(6, "baud_8", KIND_BAUD, 8'd8, '0, 1'b0);
        add_entry(7, "tx_fast", KIND_TX, rand_byte(), '0, 1'b0);
        add_entry(8, "rx_fast", KIND_RX, rand_byte(), ST_RX_FULL, 1'b1);
        add_entry(9, "tx_fast_again", KIND_TX, rand_byte(), '0, 1'b0);

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        if (uart_tx !== 1'b1) abort_run("transmit line is not idle high after reset");
        bus_read(`UART_REG_BAUD, rd);
        check_div("baud_reset", uart_types_pkg::baud_div_t'(`UART_DIV_RESET),
                  rd[`UART_DIV_WIDTH-1:0]);
        bus_read(`UART_REG_STATUS, rd);
        check_status("status_reset", '0, rd);

        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* files.f */
+incdir+include
src/uart_types_pkg.sv
src/wb_types_pkg.sv
src/uart_line_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_wb_regs.sv
src/uart_top.sv
tests/uart_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f files.f --top-module uart_tb -o uart_sim

# The simulator exits non-zero on a failed check, the log decides the result
./obj_dir/uart_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
exit 1
